/* common/bus_pkg.sv */
package bus_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  id_t;
    typedef logic [1:0]  resp_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_DECERR = 2'd3;

    // address bits 31..28 pick the window, 0x2000_0000 .. 0x2FFF_FFFF
    localparam logic [3:0] LED_WINDOW = 4'h2;

    // register offsets inside the led window
    localparam addr_t LED_REG_OFFSET     = 32'h0;
    localparam addr_t SCRATCH_REG_OFFSET = 32'h4;

    // single-beat request, reads and writes share it
    typedef struct packed {
        id_t   id;      // stamped by req_issue
        logic  wr;      // 1 write, 0 read
        addr_t addr;
        data_t wdata;
    } bus_req_t;

    typedef struct packed {
        id_t   id;
        resp_t resp;
        data_t rdata;   // zero for writes and decode errors
    } bus_rsp_t;

endpackage

/* common/panel_pkg.sv */
package panel_pkg;

    typedef logic [7:0] status_t;
    typedef logic [2:0] panel_idx_t;

    localparam int PANEL_ENTRIES = 8;

    // fixed bytes shown on entries 3 to 7
    localparam status_t PANEL_PATTERNS [5] = '{
        8'h0F,
        8'hAA,
        8'h55,
        8'hF0,
        8'h0F
    };

endpackage

/* bus/req_issue.sv */
module req_issue #(
    parameter int OUTSTANDING_MAX = 4
) (
    input  logic              sys_clk,
    input  logic              rst,
    input  bus_pkg::bus_req_t req,
    input  logic              req_valid,
    output logic              req_ready,
    output logic              push,
    output bus_pkg::bus_req_t push_req,
    input  logic              rsp_valid,
    input  logic              rsp_ready
);

    localparam int CNT_W = $clog2(OUTSTANDING_MAX + 1);

    logic [CNT_W-1:0] outstanding;
    bus_pkg::id_t     next_id;
    logic             accept;
    logic             done;

    // counts requests from acceptance until their response is taken
    assign req_ready = (outstanding != CNT_W'(OUTSTANDING_MAX));
    assign accept    = req_valid && req_ready;
    assign done      = rsp_valid && rsp_ready;

    assign push = accept; // same cycle as acceptance

    always_comb begin
        push_req    = req;
        push_req.id = next_id;
    end

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            outstanding <= '0;
            next_id     <= '0;
        end else begin
            if (accept) begin
                next_id <= next_id + 1'b1; // wraps at 16
            end
            case ({accept, done})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

endmodule

/* bus/req_fifo.sv */
module req_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic              sys_clk,
    input  logic              rst,
    input  logic              push,
    input  bus_pkg::bus_req_t push_req,
    input  logic              pop,
    output bus_pkg::bus_req_t head,
    output logic              not_empty,
    output logic [7:0]        level
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    bus_pkg::bus_req_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;

    // depth never smaller than the outstanding limit, so no full check
    always_ff @(posedge sys_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_req;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push) begin
                if (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop) begin
                if (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    assign head      = mem[rd_ptr]; // valid while not_empty
    assign not_empty = (level != 8'd0);

endmodule

/* bus/addr_router.sv */
module addr_router (
    input  logic                 sys_clk,
    input  logic                 rst,
    input  bus_pkg::bus_req_t    head,
    input  logic                 not_empty,
    output logic                 pop,
    output logic                 slave_wr,
    output logic                 slave_rd,
    output logic                 slave_sel,
    output bus_pkg::data_t       slave_wdata,
    input  bus_pkg::data_t       slave_rdata,
    output bus_pkg::bus_rsp_t    rsp,
    output logic                 rsp_valid,
    input  logic                 rsp_ready,
    output panel_pkg::status_t   decerr_count
);

    // the offset bit that tells the two registers apart
    localparam bus_pkg::addr_t REG_SEL_MASK =
        bus_pkg::LED_REG_OFFSET ^ bus_pkg::SCRATCH_REG_OFFSET;

    logic in_led;
    logic take;

    assign take   = rsp_valid && rsp_ready;
    assign in_led = (head.addr[31:28] == bus_pkg::LED_WINDOW);

    // pop when the response slot is free or emptying this cycle
    assign pop = not_empty && (!rsp_valid || rsp_ready);

    assign slave_wr    = pop && in_led && head.wr;
    assign slave_rd    = pop && in_led && !head.wr;
    assign slave_sel   = |(head.addr & REG_SEL_MASK);
    assign slave_wdata = head.wdata;

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            rsp_valid    <= 1'b0;
            decerr_count <= '0;
        end else begin
            if (pop) begin
                rsp_valid <= 1'b1;
            end else if (take) begin
                rsp_valid <= 1'b0;
            end
            if (pop && !in_led && (decerr_count != '1)) begin
                decerr_count <= decerr_count + 1'b1; // saturates at 255
            end
        end
    end

    // response held until the responder takes it
    always_ff @(posedge sys_clk) begin
        if (pop) begin
            rsp.id <= head.id;
            if (in_led) begin
                rsp.resp  <= bus_pkg::RESP_OKAY;
                rsp.rdata <= slave_rdata; // zero on writes
            end else begin
                rsp.resp  <= bus_pkg::RESP_DECERR;
                rsp.rdata <= '0;
            end
        end
    end

endmodule

/* logic/led_slave.sv */
module led_slave (
    input  logic               sys_clk,
    input  logic               rst,
    input  logic               wr,
    input  logic               rd,
    input  logic               sel,
    input  bus_pkg::data_t     wdata,
    output bus_pkg::data_t     rdata,
    output panel_pkg::status_t led_value
);

    panel_pkg::status_t led_reg;
    bus_pkg::data_t     scratch_reg;

    // sel 0 led register, 1 scratch
    always_ff @(posedge sys_clk) begin
        if (rst) begin
            led_reg     <= '0;
            scratch_reg <= '0;
        end else if (wr) begin
            if (sel) begin
                scratch_reg <= wdata;
            end else begin
                led_reg <= wdata[7:0]; // low byte only
            end
        end
    end

    always_comb begin
        if (!rd) begin
            rdata = '0;
        end else if (sel) begin
            rdata = scratch_reg;
        end else begin
            rdata = {24'd0, led_reg};
        end
    end

    assign led_value = led_reg;

endmodule

/* logic/status_panel.sv */
module status_panel (
    input  logic               sys_clk,
    input  logic               rst,
    input  logic               btn_up,
    input  logic               btn_down,
    input  panel_pkg::status_t fifo_level,
    input  panel_pkg::status_t led_value,
    input  panel_pkg::status_t decerr_count,
    output panel_pkg::status_t led8,
    output logic [3:0]         led4
);

    localparam panel_pkg::panel_idx_t LAST_IDX =
        panel_pkg::panel_idx_t'(panel_pkg::PANEL_ENTRIES - 1);

    panel_pkg::panel_idx_t idx;
    panel_pkg::status_t    entries [panel_pkg::PANEL_ENTRIES];
    logic                  btn_up_q;
    logic                  btn_down_q;
    logic                  up_rise;
    logic                  down_rise;

    assign up_rise   = btn_up && !btn_up_q;
    assign down_rise = btn_down && !btn_down_q;

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            btn_up_q   <= 1'b0;
            btn_down_q <= 1'b0;
            idx        <= '0;
        end else begin
            btn_up_q   <= btn_up;
            btn_down_q <= btn_down;
            // both edges together cancel out
            if (up_rise && !down_rise) begin
                idx <= (idx == LAST_IDX) ? '0 : idx + 1'b1;
            end else if (down_rise && !up_rise) begin
                idx <= (idx == '0) ? LAST_IDX : idx - 1'b1;
            end
        end
    end

    always_comb begin
        entries[0] = fifo_level;
        entries[1] = led_value;
        entries[2] = decerr_count;
        for (int i = 3; i < panel_pkg::PANEL_ENTRIES; i++) begin
            entries[i] = panel_pkg::PANEL_PATTERNS[i - 3];
        end
    end

    // leds are active low
    always_ff @(posedge sys_clk) begin
        if (rst) begin
            led8 <= '1;
        end else begin
            led8 <= ~entries[idx];
        end
    end

    assign led4 = {1'b0, idx};

endmodule

/* logic/bus_panel_top.sv */
module bus_panel_top #(
    parameter int OUTSTANDING_MAX = 4,
    parameter int FIFO_DEPTH      = 4   // at least OUTSTANDING_MAX
) (
    input  logic               sys_clk,
    input  logic               rst,
    input  bus_pkg::bus_req_t  req,
    input  logic               req_valid,
    output logic               req_ready,
    output bus_pkg::bus_rsp_t  rsp,
    output logic               rsp_valid,
    input  logic               rsp_ready,
    input  logic               btn_up,
    input  logic               btn_down,
    output panel_pkg::status_t led8,
    output logic [3:0]         led4
);

    logic               push;
    bus_pkg::bus_req_t  push_req;
    bus_pkg::bus_req_t  head;
    logic               not_empty;
    logic               pop;
    panel_pkg::status_t fifo_level;
    logic               slave_wr;
    logic               slave_rd;
    logic               slave_sel;
    bus_pkg::data_t     slave_wdata;
    bus_pkg::data_t     slave_rdata;
    panel_pkg::status_t led_value;
    panel_pkg::status_t decerr_count;

    req_issue #(
        .OUTSTANDING_MAX (OUTSTANDING_MAX)
    ) u_req_issue (
        .sys_clk   (sys_clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .push      (push),
        .push_req  (push_req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

    req_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_req_fifo (
        .sys_clk   (sys_clk),
        .rst       (rst),
        .push      (push),
        .push_req  (push_req),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .level     (fifo_level)
    );

    addr_router u_addr_router (
        .sys_clk      (sys_clk),
        .rst          (rst),
        .head         (head),
        .not_empty    (not_empty),
        .pop          (pop),
        .slave_wr     (slave_wr),
        .slave_rd     (slave_rd),
        .slave_sel    (slave_sel),
        .slave_wdata  (slave_wdata),
        .slave_rdata  (slave_rdata),
        .rsp          (rsp),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .decerr_count (decerr_count)
    );

    led_slave u_led_slave (
        .sys_clk   (sys_clk),
        .rst       (rst),
        .wr        (slave_wr),
        .rd        (slave_rd),
        .sel       (slave_sel),
        .wdata     (slave_wdata),
        .rdata     (slave_rdata),
        .led_value (led_value)
    );

    status_panel u_status_panel (
        .sys_clk      (sys_clk),
        .rst          (rst),
        .btn_up       (btn_up),
        .btn_down     (btn_down),
        .fifo_level   (fifo_level),
        .led_value    (led_value),
        .decerr_count (decerr_count),
        .led8         (led8),
        .led4         (led4)
    );

endmodule

/* sim/bus_panel_props.sv */
module bus_panel_props (
    input logic              sys_clk,
    input logic              rst,
    input bus_pkg::bus_rsp_t rsp,
    input logic              rsp_valid,
    input logic              rsp_ready,
    input logic              req_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    // held response stays put until taken
    rsp_held: assert property (
        @(posedge sys_clk) disable iff (rst)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp))
    ) else $error("held response changed before rsp_ready");

    rsp_idle_after_rst: assert property (
        @(posedge sys_clk) rst |=> !rsp_valid
    ) else $error("rsp_valid high in the cycle after reset");

    req_ready_after_rst: assert property (
        @(posedge sys_clk) rst |=> req_ready
    ) else $error("req_ready low after reset");

endmodule

/* sim/tb_bus_panel.sv */
module tb_bus_panel;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int OUTSTANDING_MAX = 4;
    localparam int FIFO_DEPTH      = 4;

    typedef struct packed {
        logic               wr;
        bus_pkg::addr_t     addr;
        bus_pkg::data_t     wdata;
        bus_pkg::resp_t     resp;   // expected response code
        bus_pkg::data_t     rdata;  // expected read data
    } row_t;

    logic               sys_clk = 1'b0;
    logic               rst;
    bus_pkg::bus_req_t  req;
    logic               req_valid;
    logic               req_ready;
    bus_pkg::bus_rsp_t  rsp;
    logic               rsp_valid;
    logic               rsp_ready;
    logic               btn_up;
    logic               btn_down;
    panel_pkg::status_t led8;
    logic [3:0]         led4;

    row_t               tbl [64];
    bus_pkg::bus_rsp_t  exp_q [$];
    int                 n_rows;
    int                 p1_rows;
    int                 row_idx;
    int                 row_end;
    int                 accepted;
    int                 checks;
    int                 errors;
    int                 cycles = 0;
    int                 timeout_limit = 100000;
    logic               gaps;
    logic               hold_rsp;
    bus_pkg::id_t       exp_id;
    logic [2:0]         exp_idx;
    logic [15:0]        lfsr = 16'd97;
    panel_pkg::status_t led_model;
    panel_pkg::status_t decerr_model;

    bus_panel_top #(
        .OUTSTANDING_MAX (OUTSTANDING_MAX),
        .FIFO_DEPTH      (FIFO_DEPTH)
    ) bus_panel_top_i (
        .sys_clk   (sys_clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .btn_up    (btn_up),
        .btn_down  (btn_down),
        .led8      (led8),
        .led4      (led4)
    );

    bind bus_panel_top bus_panel_props props_i (
        .sys_clk   (sys_clk),
        .rst       (rst),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .req_ready (req_ready)
    );

    always #4 sys_clk = ~sys_clk;

    always @(posedge sys_clk) begin
        cycles <= cycles + 1;
        if (cycles > timeout_limit) begin
            $display("timeout: run did not finish within %0d cycles", timeout_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    // galois lfsr, one step per bit
    function automatic logic next_bit();
        logic out;
        out  = lfsr[0];
        lfsr = out ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        return out;
    endfunction

    function automatic bus_pkg::data_t rand_word();
        bus_pkg::data_t v;
        v = '0;
        for (int i = 0; i < 32; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    function automatic panel_pkg::status_t rand_byte();
        panel_pkg::status_t v;
        v = '0;
        for (int i = 0; i < 8; i++) begin
            v = {v[6:0], next_bit()};
        end
        return v;
    endfunction

    task automatic add_row(input logic wr, input bus_pkg::addr_t addr,
                           input bus_pkg::data_t wdata, input bus_pkg::resp_t resp,
                           input bus_pkg::data_t rdata);
        tbl[n_rows] = {wr, addr, wdata, resp, rdata};
        if (resp == bus_pkg::RESP_DECERR) begin
            decerr_model = decerr_model + 8'd1;
        end
        n_rows = n_rows + 1;
    endtask

    task automatic build_table();
        bus_pkg::data_t w;
        w = rand_word();
        add_row(1'b1, 32'h2000_0000, w, bus_pkg::RESP_OKAY, '0);
        add_row(1'b0, 32'h2000_0000, '0, bus_pkg::RESP_OKAY, {24'd0, w[7:0]});
        w = rand_word();
        add_row(1'b1, 32'h2000_0004, w, bus_pkg::RESP_OKAY, '0);
        add_row(1'b0, 32'h2000_0004, '0, bus_pkg::RESP_OKAY, w);
        // outside the led window
        add_row(1'b1, 32'h1000_0000, rand_word(), bus_pkg::RESP_DECERR, '0);
        add_row(1'b0, 32'h3000_0010, '0, bus_pkg::RESP_DECERR, '0);
        add_row(1'b0, 32'hF000_0000, '0, bus_pkg::RESP_DECERR, '0);
        add_row(1'b0, 32'h0000_0004, '0, bus_pkg::RESP_DECERR, '0);
        for (int k = 0; k < 8; k++) begin
            w = rand_word();
            add_row(1'b1, 32'h2000_0004, w, bus_pkg::RESP_OKAY, '0);
            add_row(1'b0, 32'h2000_0004, '0, bus_pkg::RESP_OKAY, w);
        end
        led_model = rand_byte();
        add_row(1'b1, 32'h2000_0000, {24'hA5A5A5, led_model}, bus_pkg::RESP_OKAY, '0);
        add_row(1'b0, 32'h2000_0000, '0, bus_pkg::RESP_OKAY, {24'd0, led_model});
        p1_rows = n_rows;
        // back-pressure rows read the last scratch word
        for (int k = 0; k <= OUTSTANDING_MAX; k++) begin
            add_row(1'b0, 32'h2000_0004, '0, bus_pkg::RESP_OKAY, w);
        end
    endtask

    task automatic bus_step();
        bus_pkg::bus_rsp_t exp_rsp;
        @(posedge sys_clk);
        if (rsp_valid && rsp_ready) begin
            checks = checks + 1;
            assert (exp_q.size() > 0) else begin
                errors = errors + 1;
                $display("response arrived with no request outstanding at %0t", $time);
            end
            if (exp_q.size() > 0) begin
                exp_rsp = exp_q.pop_front();
                assert (rsp == exp_rsp) else begin
                    errors = errors + 1;
                    $display("[FAIL] %0t: rsp id/code/data %0d/%0d/%h, expected %0d/%0d/%h",
                             $time, rsp.id, rsp.resp, rsp.rdata,
                             exp_rsp.id, exp_rsp.resp, exp_rsp.rdata);
                end
            end
        end
        if (req_valid && req_ready) begin
            exp_rsp.id    = exp_id;
            exp_rsp.resp  = tbl[row_idx].resp;
            exp_rsp.rdata = tbl[row_idx].rdata;
            exp_q.push_back(exp_rsp);
            exp_id   = exp_id + 4'd1;   // wraps at 16
            row_idx  = row_idx + 1;
            accepted = accepted + 1;
        end
        if (!(req_valid && !req_ready)) begin
            if (row_idx < row_end && (!gaps || next_bit())) begin
                req       <= {4'd0, tbl[row_idx].wr, tbl[row_idx].addr, tbl[row_idx].wdata};
                req_valid <= 1'b1;
            end else begin
                req_valid <= 1'b0;
            end
        end
        rsp_ready <= hold_rsp ? 1'b0 : (gaps ? next_bit() : 1'b1);
    endtask

    function automatic panel_pkg::status_t panel_entry(input logic [2:0] idx);
        case (idx)
            3'd0:    return 8'h00;  // fifo level with the bus idle
            3'd1:    return led_model;
            3'd2:    return decerr_model;
            3'd3:    return 8'h0F;
            3'd4:    return 8'hAA;
            3'd5:    return 8'h55;
            3'd6:    return 8'hF0;
            default: return 8'h0F;
        endcase
    endfunction

    task automatic check_panel();
        checks = checks + 1;
        assert (led8 == ~panel_entry(exp_idx) && led4 == {1'b0, exp_idx}) else begin
            errors = errors + 1;
            $display("[FAIL] %0t: led8 %h led4 %0d, expected led8 %h led4 %0d",
                     $time, led8, led4, ~panel_entry(exp_idx), exp_idx);
        end
    endtask

    task automatic press(input logic up);
        @(posedge sys_clk);
        if (up) begin
            btn_up <= 1'b1;
        end else begin
            btn_down <= 1'b1;
        end
        @(posedge sys_clk);
        btn_up   <= 1'b0;
        btn_down <= 1'b0;
        exp_idx = up ? exp_idx + 3'd1 : exp_idx - 3'd1;
        repeat (3) @(posedge sys_clk); // index, then registered led8
        check_panel();
    endtask

    initial begin
        rst = 1'b1;
        req = '0;
        req_valid = 1'b0;
        rsp_ready = 1'b0;
        btn_up = 1'b0;
        btn_down = 1'b0;
        n_rows = 0;
        row_idx = 0;
        accepted = 0;
        checks = 0;
        errors = 0;
        exp_id = '0;
        exp_idx = '0;
        decerr_model = '0;
        build_table();
        timeout_limit = 40 * n_rows + 200;
        repeat (3) @(posedge sys_clk);
        rst <= 1'b0;

        // random gaps on both handshakes
        gaps = 1'b1;
        hold_rsp = 1'b0;
        row_end = p1_rows;
        while (row_idx < row_end || exp_q.size() > 0) begin
            bus_step();
        end

        // responder stalled, then released
        gaps = 1'b0;
        hold_rsp = 1'b1;
        row_end = n_rows;
        accepted = 0;
        repeat (30) bus_step();
        checks = checks + 1;
        assert (accepted == OUTSTANDING_MAX && !req_ready) else begin
            errors = errors + 1;
            $display("[FAIL] %0t: %0d requests accepted under back-pressure, expected %0d",
                     $time, accepted, OUTSTANDING_MAX);
        end
        hold_rsp = 1'b0;
        while (row_idx < row_end || exp_q.size() > 0) begin
            bus_step();
        end

        repeat (4) @(posedge sys_clk);
        check_panel();
        for (int k = 0; k < 8; k++) begin
            press(1'b1);
        end
        press(1'b0);
        press(1'b0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* verilog.f */
common/bus_pkg.sv
common/panel_pkg.sv
bus/req_issue.sv
bus/req_fifo.sv
bus/addr_router.sv
logic/led_slave.sv
logic/status_panel.sv
logic/bus_panel_top.sv
sim/bus_panel_props.sv
sim/tb_bus_panel.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_bus_panel
FILELIST  := verilog.f
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@$(SIM) | tee /dev/stderr | grep -q '^\*\* PASS \*\*$$'

clean:
	rm -rf $(OBJDIR)
